// ==== verilog/polar_defines.svh ====
`ifndef POLAR_DEFINES_SVH
`define POLAR_DEFINES_SVH

// ----------------------------------------------------------------------
// code geometry
// ----------------------------------------------------------------------
`define POLAR_N         16
`define POLAR_LOG_N     ($clog2(`POLAR_N))

// ----------------------------------------------------------------------
// datapath and memory widths
// ----------------------------------------------------------------------
// input llr as stored in memory
`define POLAR_LLR_W     12
// internal metric, wider so g sums keep their sign
`define POLAR_METRIC_W  14
`define POLAR_RWORD_W   192
`define POLAR_RADDR_W   11
`define POLAR_WADDR_W   6

`endif

// ==== verilog/polar_llr_pkg.sv ====
`include "polar_defines.svh"

package polar_llr_pkg;

    // channel llr, two's complement
    typedef logic signed [`POLAR_LLR_W-1:0] llr_t;

    // metric inside the tree
    typedef logic signed [`POLAR_METRIC_W-1:0] metric_t;

    // one bit per code position
    // frozen mask and decoded info word share this shape
    typedef logic [`POLAR_N-1:0] bitvec_t;

    // all llrs of one codeword, element 0 in the low bits
    typedef llr_t [`POLAR_N-1:0] llr_vec_t;

endpackage

// ==== verilog/polar_mem_pkg.sv ====
`include "polar_defines.svh"

package polar_mem_pkg;

    typedef logic [`POLAR_RWORD_W-1:0] rword_t;
    typedef logic [6:0] pkt_cnt_t;

    // word 0 of the input memory
    typedef struct packed {
        logic [`POLAR_RWORD_W-8:0] rsvd;
        pkt_cnt_t                  count;
    } count_hdr_t;

    // first word of each packet, 1 marks a frozen position
    typedef struct packed {
        logic [`POLAR_RWORD_W-`POLAR_N-1:0] rsvd;
        polar_llr_pkg::bitvec_t             frozen;
    } pkt_hdr_t;

    typedef union packed {
        count_hdr_t cnt;
        pkt_hdr_t   pkt;
    } hdr_t;

    // second word of each packet fills the whole read word
    typedef polar_llr_pkg::llr_vec_t llr_word_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_COUNT,
        READ_HDR,
        READ_LLR,
        DECODE,
        WRITE,
        DONE
    } ctrl_state_t;

endpackage

// ==== verilog/sc_if.sv ====
`timescale 1ns/100ps

interface sc_if;

    // one cycle, only while the core is idle
    logic                     start;
    polar_llr_pkg::llr_vec_t  llr_word;

    // one cycle, info_bits valid alongside
    logic                     done;
    polar_llr_pkg::bitvec_t   info_bits;

    modport ctrl (
        output start,
        output llr_word,
        input  done,
        input  info_bits
    );

    modport core (
        input  start,
        input  llr_word,
        output done,
        output info_bits
    );

endinterface

// ==== verilog/frame_cfg_regs.sv ====
`timescale 1ns/100ps

module frame_cfg_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_count,
    input  logic                    load_mask,
    input  polar_mem_pkg::rword_t   rdata,
    output polar_mem_pkg::pkt_cnt_t packet_count,
    output polar_llr_pkg::bitvec_t  frozen_mask
);

    polar_mem_pkg::hdr_t hdr;

    // same read word, two views
    assign hdr = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            packet_count <= '0;
            frozen_mask  <= '0;
        end else begin
            // count once per run
            if (load_count) begin
                packet_count <= hdr.cnt.count;
            end
            // mask once per packet, held through decode
            if (load_mask) begin
                frozen_mask <= hdr.pkt.frozen;
            end
        end
    end

endmodule

// ==== verilog/sc_core.sv ====
`timescale 1ns/100ps
`include "polar_defines.svh"

module sc_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  polar_llr_pkg::bitvec_t frozen_mask,
    sc_if.core                     sc
);

    localparam int N       = `POLAR_N;
    localparam int LOG_N   = `POLAR_LOG_N;
    localparam int HALF    = N / 2;
    localparam int PAIR_W  = LOG_N - 1;
    localparam int STG_W   = $clog2(LOG_N);
    localparam int MSB     = `POLAR_METRIC_W - 1;
    localparam int MET_MAX = 2 ** MSB - 1;

    polar_llr_pkg::llr_vec_t llr_q;
    // stage s keeps 2^s metrics starting at 2^s - 2
    polar_llr_pkg::metric_t  tree_q [N-2];
    polar_llr_pkg::bitvec_t  u_q;
    polar_llr_pkg::bitvec_t  enc [LOG_N];
    polar_llr_pkg::bitvec_t  info;
    polar_llr_pkg::metric_t  pa [HALF];
    polar_llr_pkg::metric_t  pb [HALF];
    polar_llr_pkg::metric_t  f_out [HALF];
    polar_llr_pkg::metric_t  g_out [HALF];
    logic [HALF-1:0]         ps;
    logic [HALF-1:0]         pu;
    logic [STG_W-1:0]        stg_q;
    logic [STG_W-1:0]        stg_nx;
    logic [PAIR_W-1:0]       pair_q;
    logic [PAIR_W-1:0]       pair_nx;
    logic [PAIR_W-1:0]       pair_flip;
    logic                    busy_q;
    logic                    done_q;
    logic                    leaf;
    logic                    u_lo;
    logic                    u_hi;

    // ----------------------------------------------------------------------
    // f/g array
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < HALF; i++) begin : g_pe
        polar_llr_pkg::metric_t        abs_a;
        polar_llr_pkg::metric_t        abs_b;
        polar_llr_pkg::metric_t        mag;
        logic signed [`POLAR_METRIC_W:0] ext_a;
        logic signed [`POLAR_METRIC_W:0] ext_b;
        logic signed [`POLAR_METRIC_W:0] sum;

        assign abs_a    = pa[i][MSB] ? -pa[i] : pa[i];
        assign abs_b    = pb[i][MSB] ? -pb[i] : pb[i];
        assign mag      = (abs_a < abs_b) ? abs_a : abs_b;
        assign f_out[i] = (pa[i][MSB] ^ pb[i][MSB]) ? -mag : mag;

        assign ext_a = pa[i];
        assign ext_b = pb[i];
        assign sum   = pu[i] ? ext_b - ext_a : ext_b + ext_a;
        // saturate symmetric, keeps abs() in range next layer
        assign g_out[i] = (sum > MET_MAX)  ? polar_llr_pkg::metric_t'(MET_MAX)  :
                          (sum < -MET_MAX) ? polar_llr_pkg::metric_t'(-MET_MAX) :
                                             polar_llr_pkg::metric_t'(sum);
    end

    // partial sums, one xor butterfly layer per stage
    always_comb begin
        enc[0] = u_q;
        for (int k = 0; k < LOG_N - 1; k++) begin
            enc[k+1] = enc[k];
            for (int j = 0; j < N; j++) begin
                if (((j >> k) & 1) == 0) begin
                    enc[k+1][j] = enc[k][j] ^ enc[k][j + (1 << k)];
                end
            end
        end
    end

    // operand select for the stage being computed
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            pa[i] = '0;
            pb[i] = '0;
            ps[i] = 1'b0;
        end
        if (stg_q == STG_W'(LOG_N - 1)) begin
            for (int i = 0; i < HALF; i++) begin
                pa[i] = polar_llr_pkg::metric_t'(llr_q[i]);
                pb[i] = polar_llr_pkg::metric_t'(llr_q[i + HALF]);
                ps[i] = enc[LOG_N-1][i];
            end
        end
        for (int s = 1; s < LOG_N - 1; s++) begin
            if (stg_q == STG_W'(s)) begin
                for (int i = 0; i < (1 << s); i++) begin
                    pa[i] = tree_q[(2 << s) - 2 + i];
                    pb[i] = tree_q[(2 << s) - 2 + (1 << s) + i];
                    ps[i] = enc[s][((int'(pair_q) >> s) << (s + 1)) + i];
                end
            end
        end
        if (stg_q == '0) begin
            pa[0] = tree_q[0];
            pb[0] = tree_q[1];
        end
    end

    // ----------------------------------------------------------------------
    // leaf pair decision
    // ----------------------------------------------------------------------
    assign leaf = (stg_q == '0);
    assign u_lo = ~frozen_mask[{pair_q, 1'b0}] & f_out[0][MSB];
    assign u_hi = ~frozen_mask[{pair_q, 1'b1}] & g_out[0][MSB];
    // second leaf bit uses the first through g
    assign pu   = ps | HALF'(leaf & u_lo);

    // restart at the highest stage whose f/g branch flips
    assign pair_nx   = pair_q + 1'b1;
    assign pair_flip = pair_q ^ pair_nx;
    always_comb begin
        stg_nx = '0;
        for (int k = 0; k < PAIR_W; k++) begin
            if (pair_flip[k]) begin
                stg_nx = STG_W'(k + 1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            stg_q  <= '0;
            pair_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (sc.start && !busy_q) begin
                busy_q <= 1'b1;
                stg_q  <= STG_W'(LOG_N - 1);
                pair_q <= '0;
            end else if (busy_q) begin
                if (!leaf) begin
                    stg_q <= stg_q - 1'b1;
                end else if (&pair_q) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    pair_q <= pair_nx;
                    stg_q  <= stg_nx;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sc.start && !busy_q) begin
            llr_q <= sc.llr_word;
        end
        if (busy_q && leaf) begin
            u_q[{pair_q, 1'b0}] <= u_lo;
            u_q[{pair_q, 1'b1}] <= u_hi;
        end
        for (int s = 1; s < LOG_N; s++) begin
            if (busy_q && stg_q == STG_W'(s)) begin
                for (int i = 0; i < (1 << s); i++) begin
                    tree_q[(1 << s) - 2 + i] <= pair_q[s-1] ? g_out[i] : f_out[i];
                end
            end
        end
    end

    // info bits, lsb first in ascending position
    always_comb begin
        automatic int k;
        k    = 0;
        info = '0;
        for (int i = 0; i < N; i++) begin
            if (!frozen_mask[i]) begin
                info[k] = u_q[i];
                k++;
            end
        end
    end

    assign sc.done      = done_q;
    assign sc.info_bits = info;

endmodule

// ==== verilog/packet_ctrl.sv ====
`timescale 1ns/100ps
`include "polar_defines.svh"

module packet_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      module_en,
    input  polar_mem_pkg::rword_t     rdata,
    input  polar_mem_pkg::pkt_cnt_t   packet_count,
    output logic [`POLAR_RADDR_W-1:0] raddr,
    output logic [`POLAR_WADDR_W-1:0] waddr,
    output logic                      wen,
    output polar_llr_pkg::bitvec_t    wdata,
    output logic                      proc_done,
    output logic                      load_count,
    output logic                      load_mask,
    sc_if.ctrl                        sc
);

    polar_mem_pkg::ctrl_state_t state_q;
    polar_mem_pkg::ctrl_state_t state_nx;
    polar_mem_pkg::pkt_cnt_t    pkt_idx_q;
    polar_mem_pkg::hdr_t        hdr;
    logic                       first_hdr;
    logic                       last_pkt;
    logic                       start_q;

    assign hdr = rdata;

    // word 0 arrives while the first packet header address is out
    assign first_hdr = (state_q == polar_mem_pkg::READ_HDR) && (raddr == 1);
    assign last_pkt  = ((pkt_idx_q + 7'd1) == packet_count);

    always_comb begin
        state_nx = state_q;
        case (state_q)
            polar_mem_pkg::IDLE,
            polar_mem_pkg::DONE: begin
                if (module_en) begin
                    state_nx = polar_mem_pkg::READ_COUNT;
                end
            end
            polar_mem_pkg::READ_COUNT: state_nx = polar_mem_pkg::READ_HDR;
            polar_mem_pkg::READ_HDR: begin
                if (first_hdr && hdr.cnt.count == '0) begin
                    state_nx = polar_mem_pkg::DONE;
                end else begin
                    state_nx = polar_mem_pkg::READ_LLR;
                end
            end
            polar_mem_pkg::READ_LLR: state_nx = polar_mem_pkg::DECODE;
            polar_mem_pkg::DECODE: begin
                if (sc.done) begin
                    state_nx = polar_mem_pkg::WRITE;
                end
            end
            polar_mem_pkg::WRITE: begin
                state_nx = last_pkt ? polar_mem_pkg::DONE : polar_mem_pkg::READ_HDR;
            end
            default: state_nx = polar_mem_pkg::IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // read address and packet index
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= polar_mem_pkg::IDLE;
            raddr     <= '0;
            pkt_idx_q <= '0;
            start_q   <= 1'b0;
        end else begin
            state_q <= state_nx;
            // llr word shows up one cycle after its address
            start_q <= (state_q == polar_mem_pkg::READ_LLR);
            case (state_q)
                polar_mem_pkg::IDLE,
                polar_mem_pkg::DONE: begin
                    if (module_en) begin
                        raddr     <= '0;
                        pkt_idx_q <= '0;
                    end
                end
                polar_mem_pkg::READ_COUNT: raddr <= raddr + 1'b1;
                polar_mem_pkg::READ_HDR: begin
                    if (state_nx == polar_mem_pkg::READ_LLR) begin
                        raddr <= raddr + 1'b1;
                    end
                end
                polar_mem_pkg::WRITE: begin
                    pkt_idx_q <= pkt_idx_q + 1'b1;
                    // no fetch past the last llr word
                    if (!last_pkt) begin
                        raddr <= raddr + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sc.done) begin
            wdata <= sc.info_bits;
        end
    end

    assign wen         = (state_q == polar_mem_pkg::WRITE);
    assign proc_done   = (state_q == polar_mem_pkg::DONE);
    assign waddr       = pkt_idx_q[`POLAR_WADDR_W-1:0];
    assign load_count  = first_hdr;
    assign load_mask   = (state_q == polar_mem_pkg::READ_LLR);
    assign sc.start    = start_q;
    assign sc.llr_word = polar_mem_pkg::llr_word_t'(rdata);

endmodule

// ==== verilog/polar_dec_top.sv ====
`timescale 1ns/100ps
`include "polar_defines.svh"

module polar_dec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      module_en,
    input  polar_mem_pkg::rword_t     rdata,
    output logic [`POLAR_RADDR_W-1:0] raddr,
    output logic [`POLAR_WADDR_W-1:0] waddr,
    output polar_llr_pkg::bitvec_t    wdata,
    output logic                      wen,
    output logic                      proc_done
);

    polar_mem_pkg::pkt_cnt_t packet_count;
    polar_llr_pkg::bitvec_t  frozen_mask;
    logic                    load_count;
    logic                    load_mask;

    sc_if sc ();

    packet_ctrl packet_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .module_en    (module_en),
        .rdata        (rdata),
        .packet_count (packet_count),
        .raddr        (raddr),
        .waddr        (waddr),
        .wen          (wen),
        .wdata        (wdata),
        .proc_done    (proc_done),
        .load_count   (load_count),
        .load_mask    (load_mask),
        .sc           (sc.ctrl)
    );

    // header fields captured straight off the read bus
    frame_cfg_regs frame_cfg_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_count   (load_count),
        .load_mask    (load_mask),
        .rdata        (rdata),
        .packet_count (packet_count),
        .frozen_mask  (frozen_mask)
    );

    sc_core sc_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frozen_mask (frozen_mask),
        .sc          (sc.core)
    );

endmodule

// ==== verif/polar_dec_assertions.sv ====
`timescale 1ns/100ps
`include "polar_defines.svh"

module polar_dec_assertions (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wen,
    input  logic                      proc_done,
    input  logic [`POLAR_RADDR_W-1:0] raddr,
    input  polar_mem_pkg::pkt_cnt_t   packet_count
);

    int fail_count = 0;

    // one write strobe per packet
    wen_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wen |=> !wen)
        else begin
            fail_count++;
            $error("wen high for two consecutive cycles");
        end

    wen_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wen && proc_done))
        else begin
            fail_count++;
            $error("wen and proc_done high in the same cycle");
        end

    // count is unknown until word 0 has been loaded
    raddr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (packet_count != '0) |-> (raddr <= {packet_count, 1'b0}))
        else begin
            fail_count++;
            $error("raddr beyond the last llr word");
        end

    done_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(proc_done) |-> $past(wen))
        else begin
            fail_count++;
            $error("proc_done rose without a write just before");
        end

endmodule

// ==== verif/tb_polar_dec.sv ====
`timescale 1ns/100ps
`include "polar_defines.svh"

module tb_polar_dec;

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_SKEW = 2;
    localparam int RESET_CYC  = 4;
    localparam int NUM_RUNS   = 2;
    // count word, three packets of two words, three expected words
    localparam int MEM_WORDS  = 10;
    localparam int PKT_CYC    = 200;
    localparam int SEED       = 47019;

    logic                      clk;
    logic                      rst_n;
    logic                      module_en;
    polar_mem_pkg::rword_t     rdata;
    logic [`POLAR_RADDR_W-1:0] raddr;
    logic [`POLAR_WADDR_W-1:0] waddr;
    polar_llr_pkg::bitvec_t    wdata;
    logic                      wen;
    logic                      proc_done;

    polar_mem_pkg::rword_t     tdata [MEM_WORDS];
    int                        pkt_count;
    int                        wr_count;
    int                        errors;
    logic                      done_prev;

    polar_dec_top polar_dec_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .module_en (module_en),
        .rdata     (rdata),
        .raddr     (raddr),
        .waddr     (waddr),
        .wdata     (wdata),
        .wen       (wen),
        .proc_done (proc_done)
    );

    bind polar_dec_top polar_dec_assertions assertions_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wen          (wen),
        .proc_done    (proc_done),
        .raddr        (raddr),
        .packet_count (packet_count)
    );

    always #(CLK_HALF) clk = ~clk;

    // synchronous read, address taken at the edge
    always @(posedge clk) rdata <= #(DRIVE_SKEW) tdata[raddr];

    function automatic polar_llr_pkg::bitvec_t expected_word(int idx);
        return tdata[1 + 2 * pkt_count + idx][`POLAR_N-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (wen) begin
                if (wr_count >= pkt_count) begin
                    errors++;
                    $display("error at %0t: more writes than packets in this run", $time);
                end else begin
                    if (int'(waddr) != wr_count) begin
                        errors++;
                        $display("mismatch at %0t: waddr got %0d expected %0d",
                                 $time, waddr, wr_count);
                    end
                    if (wdata !== expected_word(wr_count)) begin
                        errors++;
                        $display("mismatch at %0t: wdata got %h expected %h",
                                 $time, wdata, expected_word(wr_count));
                    end
                end
                wr_count++;
            end
            if (proc_done && !done_prev && wr_count != pkt_count) begin
                errors++;
                $display("error at %0t: proc_done rose after %0d of %0d writes",
                         $time, wr_count, pkt_count);
            end
            done_prev = proc_done;
        end else begin
            done_prev = 1'b0;
        end
    end

    task automatic check_idle_outputs();
        @(negedge clk);
        if (raddr !== '0) begin
            errors++;
            $display("mismatch at %0t: raddr got %h expected 0", $time, raddr);
        end
        if (wen !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: wen got %b expected 0", $time, wen);
        end
        if (proc_done !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: proc_done got %b expected 0", $time, proc_done);
        end
    endtask

    task automatic run_decoder(int run_idx);
        int gap;
        gap = $urandom_range(8, 1);
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            // previous run result held while idle
            if (run_idx > 0 && proc_done !== 1'b1) begin
                errors++;
                $display("error at %0t: proc_done dropped before the next run", $time);
            end
        end
        wr_count = 0;
        @(posedge clk);
        #(DRIVE_SKEW) module_en = 1'b1;
        @(posedge clk);
        #(DRIVE_SKEW) module_en = 1'b0;
        while (proc_done !== 1'b1) begin
            @(negedge clk);
        end
        if (wr_count != pkt_count) begin
            errors++;
            $display("error at %0t: run %0d wrote %0d words for %0d packets",
                     $time, run_idx, wr_count, pkt_count);
        end
    endtask

    task automatic report_and_finish();
        int assert_fails;
        assert_fails = polar_dec_top_i.assertions_i.fail_count;
        $display("checks finished: %0d errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        module_en = 1'b0;
        rdata     = '0;
        errors    = 0;
        wr_count  = 0;
        done_prev = 1'b0;
        void'($urandom(SEED));
        $readmemh("verif/polar_testdata.txt", tdata);
        pkt_count = int'(tdata[0][6:0]);
        repeat (RESET_CYC) @(posedge clk);
        #(DRIVE_SKEW) rst_n = 1'b1;
        check_idle_outputs();
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_decoder(r);
        end
        report_and_finish();
    end

    // watchdog sized from the packet count in the data file
    initial begin
        int limit;
        @(posedge rst_n);
        limit = NUM_RUNS * (pkt_count * PKT_CYC + 20) + 100;
        repeat (limit) @(posedge clk);
        errors++;
        $display("error at %0t: decoder did not finish within %0d cycles", $time, limit);
        report_and_finish();
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/polar_llr_pkg.sv
verilog/polar_mem_pkg.sv
verilog/sc_if.sv
verilog/frame_cfg_regs.sv
verilog/sc_core.sv
verilog/packet_ctrl.sv
verilog/polar_dec_top.sv
verif/polar_dec_assertions.sv
verif/tb_polar_dec.sv

// ==== Bender.yml ====
package:
  name: polar_dec

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/polar_llr_pkg.sv
      - verilog/polar_mem_pkg.sv
      - verilog/sc_if.sv
      - verilog/frame_cfg_regs.sv
      - verilog/sc_core.sv
      - verilog/packet_ctrl.sv
      - verilog/polar_dec_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/polar_dec_assertions.sv
      - verif/tb_polar_dec.sv

// ==== verif/polar_testdata.txt ====
// one hex word per line: word 0 packet count, then per packet a frozen mask header
// and sixteen 12-bit llrs (llr 0 rightmost), then one expected output word per packet
003
// packet 0: nothing frozen, all llrs positive
000000000000_000000000000_000000000000_000000000000
040040040040_040040040040_040040040040_040040040040
// packet 1: nothing frozen, codeword of u = 0x9088
000000000000_000000000000_000000000000_000000000000
fc0fc0fc0040_fc0fc0fc0040_040040040fc0_fc0fc0fc0040
// packet 2: only position 15 unfrozen, all llrs negative
000000000000_000000000000_000000000000_000000007fff
fc0fc0fc0fc0_fc0fc0fc0fc0_fc0fc0fc0fc0_fc0fc0fc0fc0
// expected wdata for packets 0, 1, 2
0000
9088
0001
